// File: Makefile
VERILATOR  ?= verilator
TOP        ?= bomb_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/bomb_assert.sv
`timescale 1ns/1ns

module bomb_assert #(
    parameter int unsigned max_strikes = 3
) (
    input logic                     clk,
    input logic                     nrst,
    input logic                     strobe,
    input bomb_pkg::game_state_t    game_state,
    input bomb_pkg::playing_state_t playing_state,
    input logic [1:0]               strikes,
    input logic                     game_clear
);
    import bomb_pkg::*;

    strobe_single: assert property (@(posedge clk) disable iff (!nrst) strobe |=> !strobe)
        else $error("strobe held for more than one cycle");

    // the menu always brings the player back to the panel
    menu_to_panel: assert property (@(posedge clk) disable iff (!nrst)
        game_state == MENU |=> playing_state == MOD)
        else $error("playing_state not back at the panel after the menu");

    // a full strike count only drops again when a new game starts
    strike_bound: assert property (@(posedge clk) disable iff (!nrst)
        (32'(strikes) == max_strikes && game_state != MENU)
        |=> 32'(strikes) == max_strikes)
        else $error("strike count went past its limit");

    clear_in_game: assert property (@(posedge clk) disable iff (!nrst)
        game_clear |-> (game_state == PLAY || game_state == WON))
        else $error("game_clear high outside a running or won game");

endmodule

bind bomb_top bomb_assert #(.max_strikes(max_strikes)) u_assert (
    .clk(clk), .nrst(nrst), .strobe(strobe), .game_state(game_state),
    .playing_state(playing_state), .strikes(strikes), .game_clear(game_clear)
);

// File: bench/bomb_tb.sv
`timescale 1ns/1ns

module bomb_tb;
    import bomb_pkg::*;

    localparam int          tick_div    = 20;
    localparam int          time_limit  = 200;
    localparam int          max_strikes = 3;
    localparam int          mod_num     = 3;
    localparam logic [15:0] maze_walls  = 16'h2822;
    localparam int          wire_answer = 2;
    localparam logic [7:0]  mem_key     = 8'h72;
    localparam int          period      = 100;
    // about 100 presses of 11 cycles, two resets, the idle countdown and a margin
    localparam int watchdog_cycles = 100 * 11 + 2 * 20 + time_limit * tick_div + 500;

    logic                clk;
    logic                nrst;
    logic [button_w-1:0] buttons;
    game_state_t         game_state;
    playing_state_t      playing_state;
    logic                cursor_row;
    logic                cursor_col;
    logic [1:0]          maze_row;
    logic [1:0]          maze_col;
    logic [1:0]          wire_sel;
    logic [7:0]          time_left;
    logic [1:0]          strikes;
    logic                game_clear;

    // expected outputs, kept up to date by the tests
    game_state_t    exp_game;
    playing_state_t exp_play;
    logic           exp_row;
    logic           exp_col;
    logic [1:0]     exp_maze_row;
    logic [1:0]     exp_maze_col;
    logic [1:0]     exp_wire;
    logic [1:0]     exp_strikes;
    logic           exp_clear;
    logic           maze_solved;

    int   errors;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    int   presses;
    int   compared;
    int   seed;
    event compare_now;

    bomb_top #(
        .mod_num(mod_num), .time_limit(time_limit), .tick_div(tick_div),
        .max_strikes(max_strikes), .maze_walls(maze_walls),
        .wire_answer(wire_answer), .mem_key(mem_key)
    ) DUT (
        .clk(clk), .nrst(nrst), .buttons(buttons), .game_state(game_state),
        .playing_state(playing_state), .cursor_row(cursor_row), .cursor_col(cursor_col),
        .maze_row(maze_row), .maze_col(maze_col), .wire_sel(wire_sel),
        .time_left(time_left), .strikes(strikes), .game_clear(game_clear)
    );

    always #(period / 2) clk = ~clk;

    // ************************************************************************
    // reference model and checking
    // ************************************************************************

    // direction code 0 up, 1 right, 2 down, 3 left
    function automatic logic [button_w-1:0] arrow_button(input logic [1:0] code);
        case (code)
            2'd0:    return btn_up;
            2'd1:    return btn_right;
            2'd2:    return btn_down;
            default: return btn_left;
        endcase
    endfunction

    // next maze cell, packed as {row, col, strike, goal}
    function automatic logic [5:0] maze_ref(input logic [1:0] row, input logic [1:0] col,
                                            input logic [button_w-1:0] dir);
        int r;
        int c;
        r = row;
        c = col;
        case (dir)
            btn_up:    r = r - 1;
            btn_down:  r = r + 1;
            btn_left:  c = c - 1;
            btn_right: c = c + 1;
            default:   ;
        endcase
        if (r < 0 || r > 3 || c < 0 || c > 3) begin
            return {row, col, 2'b00};
        end
        if (maze_walls[r * 4 + c]) begin
            return {row, col, 2'b10};
        end
        return {r[1:0], c[1:0], 1'b0, (r == 3 && c == 3)};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got %0h, expected %0h", name, actual, expected);
            errors++;
        end
    endtask

    always begin
        @(compare_now);
        check("game_state", 32'(game_state), 32'(exp_game));
        check("playing_state", 32'(playing_state), 32'(exp_play));
        check("cursor_row", 32'(cursor_row), 32'(exp_row));
        check("cursor_col", 32'(cursor_col), 32'(exp_col));
        check("maze_row", 32'(maze_row), 32'(exp_maze_row));
        check("maze_col", 32'(maze_col), 32'(exp_maze_col));
        check("wire_sel", 32'(wire_sel), 32'(exp_wire));
        check("strikes", 32'(strikes), 32'(exp_strikes));
        check("game_clear", 32'(game_clear), 32'(exp_clear));
        compared++;
    end

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ************************************************************************
    // stimulus
    // ************************************************************************

    task automatic apply_reset();
        @(posedge clk);
        nrst    <= 1'b0;
        buttons <= btn_none;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        exp_game     = MENU;
        exp_play     = MOD;
        exp_row      = 1'b0;
        exp_col      = 1'b0;
        exp_maze_row = 2'd0;
        exp_maze_col = 2'd0;
        exp_wire     = 2'd0;
        exp_strikes  = 2'd0;
        exp_clear    = 1'b0;
        maze_solved  = 1'b0;
    endtask

    // one button held for four cycles, then released and given time to settle
    task automatic press(input logic [button_w-1:0] code);
        @(posedge clk);
        buttons <= code;
        repeat (4) @(posedge clk);
        buttons <= btn_none;
        repeat (5) @(posedge clk);
        @(negedge clk);
        presses++;
        -> compare_now;
        wait (compared == presses);
    endtask

    task automatic maze_press(input logic [button_w-1:0] dir);
        logic [5:0] nxt;
        nxt = maze_ref(exp_maze_row, exp_maze_col, dir);
        if (!maze_solved) begin
            exp_maze_row = nxt[5:4];
            exp_maze_col = nxt[3:2];
            exp_strikes  = exp_strikes + {1'b0, nxt[1]};
            maze_solved  = nxt[0];
        end
        press(dir);
    endtask

    task automatic enter_and_leave(input playing_state_t target);
        exp_play = target;
        press(btn_select);
        exp_play = MOD;
        press(btn_back);
    endtask

    task automatic reset_and_start();
        apply_reset();
        check("game_state", 32'(game_state), 32'(MENU));
        check("playing_state", 32'(playing_state), 32'(MOD));
        check("strikes", 32'(strikes), 32'd0);
        check("time_left", 32'(time_left), 32'(time_limit));
        check("game_clear", 32'(game_clear), 32'd0);
        exp_game = PLAY;
        press(btn_select);
        check("time_left", 32'(time_left), 32'(time_limit));
        report_test("reset and start");
    endtask

    task automatic panel_navigation();
        enter_and_leave(MAZE);
        exp_col = 1'b1;
        press(btn_right);
        enter_and_leave(WIRE);
        exp_row = 1'b1;
        press(btn_down);
        enter_and_leave(MEM);
        exp_col = 1'b0;
        press(btn_left);
        enter_and_leave(MEM);
        // moves past the edges saturate
        press(btn_left);
        press(btn_down);
        exp_row = 1'b0;
        press(btn_up);
        press(btn_up);
        exp_col = 1'b1;
        press(btn_right);
        press(btn_right);
        exp_col = 1'b0;
        press(btn_left);
        report_test("panel navigation");
    endtask

    task automatic maze_walk();
        logic [5:0]          nxt;
        logic [button_w-1:0] dir;
        int                  r;
        exp_play = MAZE;
        press(btn_select);
        for (int i = 0; i < 30; i++) begin
            r   = $random(seed);
            dir = arrow_button(r[1:0]);
            nxt = maze_ref(exp_maze_row, exp_maze_col, dir);
            // a bump that would lose the game is left out
            if (!(nxt[1] && exp_strikes == 2'(max_strikes - 1))) begin
                maze_press(dir);
            end
        end
        // fresh game, maze back at the start
        apply_reset();
        exp_game = PLAY;
        press(btn_select);
        exp_play = MAZE;
        press(btn_select);
        maze_press(btn_down);
        maze_press(btn_down);
        maze_press(btn_right);
        maze_press(btn_right);
        maze_press(btn_down);
        maze_press(btn_right);
        // a solved maze ignores further arrows
        maze_press(btn_left);
        exp_play = MOD;
        press(btn_back);
        report_test("maze");
    endtask

    task automatic wire_and_memory();
        exp_col = 1'b1;
        press(btn_right);
        exp_play = WIRE;
        press(btn_select);
        // wire 0 is not the answer
        exp_strikes = exp_strikes + 2'd1;
        press(btn_select);
        while (exp_wire != 2'(wire_answer)) begin
            exp_wire = exp_wire + 2'd1;
            press(btn_right);
        end
        press(btn_select);
        exp_play = MOD;
        press(btn_back);
        exp_row = 1'b1;
        press(btn_down);
        exp_play = MEM;
        press(btn_select);
        exp_strikes = exp_strikes + 2'd1;
        press(arrow_button(mem_key[1:0] + 2'd1));
        for (int k = 0; k < 4; k++) begin
            if (k == 3) begin
                exp_clear = 1'b1;
                exp_game  = WON;
            end
            press(arrow_button(mem_key[2 * k +: 2]));
        end
        exp_game     = MENU;
        exp_play     = MOD;
        exp_row      = 1'b0;
        exp_col      = 1'b0;
        exp_clear    = 1'b0;
        exp_maze_row = 2'd0;
        exp_maze_col = 2'd0;
        exp_wire     = 2'd0;
        maze_solved  = 1'b0;
        press(btn_select);
        report_test("wire and memory");
    endtask

    task automatic losing_games();
        int cycles;
        exp_game    = PLAY;
        exp_strikes = 2'd0;
        press(btn_select);
        exp_col = 1'b1;
        press(btn_right);
        exp_play = WIRE;
        press(btn_select);
        for (int i = 0; i < 3; i++) begin
            exp_strikes = exp_strikes + 2'd1;
            if (i == 2) begin
                exp_game = LOST;
            end
            press(btn_select);
        end
        exp_game = MENU;
        exp_play = MOD;
        exp_col  = 1'b0;
        press(btn_select);
        exp_game    = PLAY;
        exp_strikes = 2'd0;
        press(btn_select);
        // idle until the countdown runs out
        cycles = 0;
        while (game_state == PLAY && cycles < time_limit * tick_div) begin
            @(negedge clk);
            cycles++;
        end
        if (game_state != LOST) begin
            $display("the countdown did not lose the game within %0d cycles", cycles);
            errors++;
        end
        if (cycles < (time_limit - 1) * tick_div) begin
            $display("the game was lost after only %0d idle cycles", cycles);
            errors++;
        end
        check("time_left", 32'(time_left), 32'd0);
        report_test("losing");
    endtask

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        buttons      = btn_none;
        seed         = 93;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        presses      = 0;
        compared     = 0;
        reset_and_start();
        panel_navigation();
        maze_walk();
        wire_and_memory();
        losing_games();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * period);
        $display("timeout, the tests did not finish within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: list.f
verilog/bomb_pkg.sv
verilog/button_strobe.sv
verilog/game_fsm.sv
verilog/fsm_playing.sv
verilog/maze_game.sv
verilog/wire_game.sv
verilog/memory_game.sv
verilog/bomb_top.sv
bench/bomb_assert.sv
bench/bomb_tb.sv

// File: verilog/bomb_pkg.sv
package bomb_pkg;

    // top level game flow
    typedef enum logic [2:0] {
        MENU = 3'd0,
        PLAY = 3'd1,
        LOST = 3'd2,
        WON  = 3'd3
    } game_state_t;

    // where the player is while a game runs
    typedef enum logic [2:0] {
        MOD  = 3'd0,
        MAZE = 3'd1,
        WIRE = 3'd2,
        MEM  = 3'd3
    } playing_state_t;

    localparam int button_w = 6;

    // one-hot button codes, select in bit 0 and back in bit 5
    localparam logic [button_w-1:0] btn_select = 6'b000001;
    localparam logic [button_w-1:0] btn_up     = 6'b000010;
    localparam logic [button_w-1:0] btn_right  = 6'b000100;
    localparam logic [button_w-1:0] btn_down   = 6'b001000;
    localparam logic [button_w-1:0] btn_left   = 6'b010000;
    localparam logic [button_w-1:0] btn_back   = 6'b100000;
    localparam logic [button_w-1:0] btn_none   = 6'b000000;

endpackage

// File: verilog/bomb_top.sv
`timescale 1ns/1ns

module bomb_top #(
    parameter int unsigned mod_num     = 3,
    parameter int unsigned time_limit  = 60,
    parameter int unsigned tick_div    = 1000,
    parameter int unsigned max_strikes = 3,
    parameter logic [15:0] maze_walls  = 16'h2822,
    parameter int unsigned wire_answer = 2,
    parameter logic [7:0]  mem_key     = 8'h72
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic [bomb_pkg::button_w-1:0] buttons,
    output bomb_pkg::game_state_t         game_state,
    output bomb_pkg::playing_state_t      playing_state,
    output logic                          cursor_row,
    output logic                          cursor_col,
    output logic [1:0]                    maze_row,
    output logic [1:0]                    maze_col,
    output logic [1:0]                    wire_sel,
    output logic [7:0]                    time_left,
    output logic [1:0]                    strikes,
    output logic                          game_clear
);
    import bomb_pkg::*;

    logic                strobe;
    logic [button_w-1:0] button;
    logic                maze_clear;
    logic                wire_clear;
    logic                mem_clear;
    logic                maze_strike;
    logic                wire_strike;
    logic                mem_strike;

    button_strobe u_strobe (
        .clk(clk), .nrst(nrst), .buttons(buttons), .strobe(strobe), .button(button)
    );

    game_fsm #(
        .time_limit(time_limit), .tick_div(tick_div), .max_strikes(max_strikes)
    ) u_game (
        .clk(clk), .nrst(nrst), .strobe(strobe), .button(button), .game_clear(game_clear),
        .maze_strike(maze_strike), .wire_strike(wire_strike), .mem_strike(mem_strike),
        .game_state(game_state), .time_left(time_left), .strikes(strikes)
    );

    fsm_playing #(.mod_num(mod_num)) u_playing (
        .clk(clk), .nrst(nrst), .strobe(strobe), .button(button), .game_state(game_state),
        .maze_clear(maze_clear), .wire_clear(wire_clear), .mem_clear(mem_clear),
        .playing_state(playing_state), .cursor_row(cursor_row), .cursor_col(cursor_col),
        .game_clear(game_clear)
    );

    // *************************************************************************
    // puzzle modules
    // *************************************************************************
    maze_game #(.maze_walls(maze_walls)) u_maze (
        .clk(clk), .nrst(nrst), .strobe(strobe), .button(button), .game_state(game_state),
        .playing_state(playing_state), .maze_row(maze_row), .maze_col(maze_col),
        .clear(maze_clear), .strike(maze_strike)
    );

    wire_game #(.wire_answer(wire_answer)) u_wire (
        .clk(clk), .nrst(nrst), .strobe(strobe), .button(button), .game_state(game_state),
        .playing_state(playing_state), .wire_sel(wire_sel),
        .clear(wire_clear), .strike(wire_strike)
    );

    memory_game #(.mem_key(mem_key)) u_mem (
        .clk(clk), .nrst(nrst), .strobe(strobe), .button(button), .game_state(game_state),
        .playing_state(playing_state), .clear(mem_clear), .strike(mem_strike)
    );

endmodule

// File: verilog/button_strobe.sv
`timescale 1ns/1ns

module button_strobe (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic [bomb_pkg::button_w-1:0] buttons,
    output logic                          strobe,
    output logic [bomb_pkg::button_w-1:0] button
);
    import bomb_pkg::*;

    logic [button_w-1:0] sync_1;
    logic [button_w-1:0] sync_2;
    logic [button_w-1:0] prev;
    logic [button_w-1:0] rise;
    logic                one_new;
    logic                single;

    assign rise    = sync_2 & ~prev;
    assign one_new = (rise != btn_none) && ((rise & (rise - 1'b1)) == btn_none);
    // nothing else may be held while the new bit comes up
    assign single  = one_new && (sync_2 == rise);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync_1 <= btn_none;
            sync_2 <= btn_none;
            prev   <= btn_none;
            strobe <= 1'b0;
            button <= btn_none;
        end else begin
            sync_1 <= buttons;
            sync_2 <= sync_1;
            prev   <= sync_2;
            strobe <= single;
            button <= single ? rise : btn_none;
        end
    end

endmodule

// File: verilog/fsm_playing.sv
`timescale 1ns/1ns

module fsm_playing #(
    parameter int unsigned mod_num = 3
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          strobe,
    input  logic [bomb_pkg::button_w-1:0] button,
    input  bomb_pkg::game_state_t         game_state,
    input  logic                          maze_clear,
    input  logic                          wire_clear,
    input  logic                          mem_clear,
    output bomb_pkg::playing_state_t      playing_state,
    output logic                          cursor_row,
    output logic                          cursor_col,
    output logic                          game_clear
);
    import bomb_pkg::*;

    playing_state_t next_state;
    logic [2:0]     num_clear;
    logic [2:0]     next_num_clear;
    logic           next_row;
    logic           next_col;
    logic           sub_clear;
    logic           restart;

    // panel map, both bottom cells open the memory puzzle
    function automatic playing_state_t panel_module(input logic row, input logic col);
        if (row) begin
            return MEM;
        end
        return col ? WIRE : MAZE;
    endfunction

    assign sub_clear  = maze_clear | wire_clear | mem_clear;
    // leaving a finished game clears the count in step with game_fsm
    assign restart    = (game_state == MENU) ||
                        (game_state != PLAY && strobe && button == btn_select);
    assign game_clear = (num_clear == 3'(mod_num));

    always_comb begin
        next_state     = playing_state;
        next_num_clear = num_clear;
        next_row       = cursor_row;
        next_col       = cursor_col;
        if (restart) begin
            next_state     = MOD;
            next_num_clear = 3'd0;
            next_row       = 1'b0;
            next_col       = 1'b0;
        end else if (game_state == PLAY) begin
            if (playing_state == MOD) begin
                if (strobe) begin
                    case (button)
                        btn_up:     next_row = 1'b0;
                        btn_down:   next_row = 1'b1;
                        btn_left:   next_col = 1'b0;
                        btn_right:  next_col = 1'b1;
                        btn_select: next_state = panel_module(cursor_row, cursor_col);
                        default:    ;
                    endcase
                end
            end else if (strobe && button == btn_back) begin
                next_state = MOD;
            end else if (sub_clear) begin
                next_num_clear = num_clear + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            playing_state <= MOD;
            num_clear     <= 3'd0;
            cursor_row    <= 1'b0;
            cursor_col    <= 1'b0;
        end else begin
            playing_state <= next_state;
            num_clear     <= next_num_clear;
            cursor_row    <= next_row;
            cursor_col    <= next_col;
        end
    end

endmodule

// File: verilog/game_fsm.sv
`timescale 1ns/1ns

module game_fsm #(
    parameter int unsigned time_limit  = 60,
    parameter int unsigned tick_div    = 1000,
    parameter int unsigned max_strikes = 3
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          strobe,
    input  logic [bomb_pkg::button_w-1:0] button,
    input  logic                          game_clear,
    input  logic                          maze_strike,
    input  logic                          wire_strike,
    input  logic                          mem_strike,
    output bomb_pkg::game_state_t         game_state,
    output logic [7:0]                    time_left,
    output logic [1:0]                    strikes
);
    import bomb_pkg::*;

    localparam int             presc_w    = $clog2(tick_div + 1);
    localparam logic [presc_w-1:0] presc_last = presc_w'(tick_div - 1);
    localparam logic [7:0]     time_init  = 8'(time_limit);
    localparam logic [1:0]     strike_lim = 2'(max_strikes);

    logic [presc_w-1:0] presc;
    logic               tick;
    logic               strike_hit;
    logic               press_select;

    assign tick         = (presc == presc_last);
    assign strike_hit   = maze_strike | wire_strike | mem_strike;
    assign press_select = strobe && (button == btn_select);

    // *************************************************************************
    // game flow, countdown and strikes
    // *************************************************************************
    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state <= MENU;
            presc      <= '0;
            time_left  <= time_init;
            strikes    <= 2'd0;
        end else begin
            case (game_state)
                MENU: begin
                    if (press_select) begin
                        game_state <= PLAY;
                        presc      <= '0;
                        time_left  <= time_init;
                        strikes    <= 2'd0;
                    end
                end
                PLAY: begin
                    presc <= tick ? '0 : presc + 1'b1;
                    if (tick && time_left != 8'd0) begin
                        time_left <= time_left - 8'd1;
                    end
                    if (strike_hit) begin
                        strikes <= strikes + 2'd1;
                    end
                    // a finished panel wins even on the last tick
                    if (game_clear) begin
                        game_state <= WON;
                    end else if (strikes >= strike_lim || time_left == 8'd0) begin
                        game_state <= LOST;
                    end
                end
                LOST, WON: begin
                    if (press_select) begin
                        game_state <= MENU;
                    end
                end
                default: game_state <= MENU;
            endcase
        end
    end

endmodule

// File: verilog/maze_game.sv
`timescale 1ns/1ns

module maze_game #(
    parameter logic [15:0] maze_walls = 16'h2822
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          strobe,
    input  logic [bomb_pkg::button_w-1:0] button,
    input  bomb_pkg::game_state_t         game_state,
    input  bomb_pkg::playing_state_t      playing_state,
    output logic [1:0]                    maze_row,
    output logic [1:0]                    maze_col,
    output logic                          clear,
    output logic                          strike
);
    import bomb_pkg::*;

    logic       solved;
    logic       active;
    logic       on_grid;
    logic [1:0] tgt_row;
    logic [1:0] tgt_col;
    logic       hit_wall;

    assign active   = strobe && game_state == PLAY && playing_state == MAZE && !solved;
    // cell index is row * 4 + col
    assign hit_wall = maze_walls[{tgt_row, tgt_col}];

    // target cell of an arrow, off the grid counts as no move
    always_comb begin
        tgt_row = maze_row;
        tgt_col = maze_col;
        on_grid = 1'b0;
        case (button)
            btn_up: begin
                on_grid = (maze_row != 2'd0);
                tgt_row = maze_row - 2'd1;
            end
            btn_down: begin
                on_grid = (maze_row != 2'd3);
                tgt_row = maze_row + 2'd1;
            end
            btn_left: begin
                on_grid = (maze_col != 2'd0);
                tgt_col = maze_col - 2'd1;
            end
            btn_right: begin
                on_grid = (maze_col != 2'd3);
                tgt_col = maze_col + 2'd1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            maze_row <= 2'd0;
            maze_col <= 2'd0;
            solved   <= 1'b0;
            clear    <= 1'b0;
            strike   <= 1'b0;
        end else begin
            clear  <= 1'b0;
            strike <= 1'b0;
            if (game_state == MENU) begin
                maze_row <= 2'd0;
                maze_col <= 2'd0;
                solved   <= 1'b0;
            end else if (active && on_grid) begin
                if (hit_wall) begin
                    strike <= 1'b1;
                end else begin
                    maze_row <= tgt_row;
                    maze_col <= tgt_col;
                    // goal is the bottom right corner
                    if (tgt_row == 2'd3 && tgt_col == 2'd3) begin
                        solved <= 1'b1;
                        clear  <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/memory_game.sv
`timescale 1ns/1ns

module memory_game #(
    parameter logic [7:0] mem_key = 8'h72
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          strobe,
    input  logic [bomb_pkg::button_w-1:0] button,
    input  bomb_pkg::game_state_t         game_state,
    input  bomb_pkg::playing_state_t      playing_state,
    output logic                          clear,
    output logic                          strike
);
    import bomb_pkg::*;

    logic [1:0] step;
    logic       solved;
    logic       active;
    logic       is_dir;
    logic [1:0] dir;
    logic [1:0] expected;

    assign active   = strobe && game_state == PLAY && playing_state == MEM && !solved;
    // key holds the steps in order from the low bits
    assign expected = mem_key[{step, 1'b0} +: 2];

    // direction code 0 up, 1 right, 2 down, 3 left
    always_comb begin
        is_dir = 1'b1;
        case (button)
            btn_up:    dir = 2'd0;
            btn_right: dir = 2'd1;
            btn_down:  dir = 2'd2;
            btn_left:  dir = 2'd3;
            default: begin
                dir    = 2'd0;
                is_dir = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            step   <= 2'd0;
            solved <= 1'b0;
            clear  <= 1'b0;
            strike <= 1'b0;
        end else begin
            clear  <= 1'b0;
            strike <= 1'b0;
            if (game_state == MENU) begin
                step   <= 2'd0;
                solved <= 1'b0;
            end else if (active && is_dir) begin
                if (dir != expected) begin
                    strike <= 1'b1;
                    step   <= 2'd0;
                end else if (step == 2'd3) begin
                    solved <= 1'b1;
                    clear  <= 1'b1;
                end else begin
                    step <= step + 2'd1;
                end
            end
        end
    end

endmodule

// File: verilog/wire_game.sv
`timescale 1ns/1ns

module wire_game #(
    parameter int unsigned wire_answer = 2
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          strobe,
    input  logic [bomb_pkg::button_w-1:0] button,
    input  bomb_pkg::game_state_t         game_state,
    input  bomb_pkg::playing_state_t      playing_state,
    output logic [1:0]                    wire_sel,
    output logic                          clear,
    output logic                          strike
);
    import bomb_pkg::*;

    logic solved;
    logic active;

    assign active = strobe && game_state == PLAY && playing_state == WIRE && !solved;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_sel <= 2'd0;
            solved   <= 1'b0;
            clear    <= 1'b0;
            strike   <= 1'b0;
        end else begin
            clear  <= 1'b0;
            strike <= 1'b0;
            if (game_state == MENU) begin
                wire_sel <= 2'd0;
                solved   <= 1'b0;
            end else if (active) begin
                case (button)
                    // selector wraps around the four wires
                    btn_left:  wire_sel <= wire_sel - 2'd1;
                    btn_right: wire_sel <= wire_sel + 2'd1;
                    btn_select: begin
                        if (wire_sel == 2'(wire_answer)) begin
                            solved <= 1'b1;
                            clear  <= 1'b1;
                        end else begin
                            strike <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule
